// ==== verilog/ix_isa_pkg.sv ====
package ix_isa_pkg;

    // Data path width, fixed by the request structs
    localparam int xlen = 64;

    // Immediate slices carried to the pipes
    localparam int br_off_w = 21;
    localparam int ls_off_w = 12;

    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] alu_op_t;
    typedef logic [1:0] br_type_t;

    typedef enum logic [2:0] {
        ot_int    = 3'd0,
        ot_branch = 3'd1,
        ot_load   = 3'd2,
        ot_store  = 3'd3
    } op_type_t;

    typedef enum logic [1:0] {
        opr1_rs1  = 2'd0,
        opr1_pc   = 2'd1,
        opr1_zero = 2'd2,
        opr1_zimm = 2'd3
    } opr1_src_t;

    typedef enum logic [1:0] {
        opr2_rs2  = 2'd0,
        opr2_imm  = 2'd1,
        opr2_four = 2'd2
    } opr2_src_t;

    typedef enum logic {
        bb_pc  = 1'b0,
        bb_rs1 = 1'b1
    } br_base_src_t;

    // Byte, half, word, double
    typedef enum logic [1:0] {
        mw_b = 2'd0,
        mw_h = 2'd1,
        mw_w = 2'd2,
        mw_d = 2'd3
    } mem_width_t;

endpackage

// ==== verilog/ix_pipe_pkg.sv ====
package ix_pipe_pkg;
    import ix_isa_pkg::*;

    // One instruction as it leaves the decoder
    typedef struct packed {
        logic [xlen-1:0] pc;
        alu_op_t         op;
        logic            option;
        logic            truncate;
        br_type_t        br_type;
        logic            br_neg;
        br_base_src_t    br_base_src;
        logic            br_inj_pc;
        logic            br_is_call;
        logic            br_is_ret;
        logic            mem_sign;
        mem_width_t      mem_width;
        op_type_t        op_type;
        opr1_src_t       opr1_src;
        opr2_src_t       opr2_src;
        logic [xlen-1:0] imm;
        logic            wb_en;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        reg_idx_t        rd;
    } dec_bundle_t;

    typedef struct packed {
        logic [xlen-1:0]     pc;
        reg_idx_t            dst;
        logic                wb_en;
        alu_op_t             op;
        logic                option;
        logic                truncate;
        br_type_t            br_type;
        logic                br_neg;
        logic [xlen-1:0]     br_base;
        logic [br_off_w-1:0] br_offset;
        logic                br_is_call;
        logic                br_is_ret;
        logic [xlen-1:0]     operand1;
        logic [xlen-1:0]     operand2;
    } ip_req_t;

    typedef struct packed {
        logic [xlen-1:0]     pc;
        reg_idx_t            dst;
        logic                wb_en;
        logic [xlen-1:0]     base;
        logic [ls_off_w-1:0] offset;
        logic [xlen-1:0]     source;
        logic                mem_sign;
        mem_width_t          mem_width;
    } lsp_req_t;

    typedef struct packed {
        logic            valid;
        logic            wb_en;
        reg_idx_t        dst;
        logic [xlen-1:0] result;
    } wb_bus_t;

    typedef struct packed {
        logic [xlen-1:0] value;
        reg_idx_t        dst;
    } ex_fwd_t;

    typedef struct packed {
        logic            busy;
        logic            wb_en;
        reg_idx_t        dst;
        logic [xlen-1:0] result;
        logic            result_valid;
    } lsp_mem_t;

    // Writeback point that is about to update idx
    function automatic logic wb_hit(input wb_bus_t bus, input reg_idx_t idx);
        return bus.valid && bus.wb_en && (bus.dst == idx);
    endfunction

endpackage

// ==== verilog/ix_operand_bypass.sv ====
`timescale 1ns/1ps

module ix_operand_bypass import ix_isa_pkg::*; import ix_pipe_pkg::*; #(
    parameter bit mem_forward = 1'b0
) (
    input  reg_idx_t        rsrc,
    input  logic [xlen-1:0] rf_rdata,
    input  wb_bus_t         wb_buf,
    input  wb_bus_t         ip0_wb,
    input  wb_bus_t         ip1_wb,
    input  wb_bus_t         lsp_wb,
    input  ex_fwd_t         ip0_fwd,
    input  ex_fwd_t         ip1_fwd,
    input  lsp_mem_t        lsp_mem,
    input  ip_req_t         ip0_out,
    input  logic            ip0_valid,
    input  logic            ip0_ready,
    input  ip_req_t         ip1_out,
    input  logic            ip1_valid,
    input  logic            ip1_ready,
    input  lsp_req_t        lsp_out,
    input  logic            lsp_valid,
    output logic [xlen-1:0] value,
    output logic            ready
);

    logic lsp_mem_hit;

    assign lsp_mem_hit = lsp_mem.busy && lsp_mem.wb_en && (lsp_mem.dst == rsrc);

    // Later checks win, so points are ordered from oldest to youngest producer
    always_comb begin
        ready = 1'b1;
        value = rf_rdata;
        if (wb_hit(wb_buf, rsrc))
            value = wb_buf.result;
        if (wb_hit(ip0_wb, rsrc))
            value = ip0_wb.result;
        if (wb_hit(ip1_wb, rsrc))
            value = ip1_wb.result;
        // Request taken by the pipe this cycle, result comes off the ALU
        if (ip0_valid && ip0_ready && ip0_out.wb_en && (ip0_fwd.dst == rsrc))
            value = ip0_fwd.value;
        if (ip1_valid && ip1_ready && ip1_out.wb_en && (ip1_fwd.dst == rsrc))
            value = ip1_fwd.value;
        if (ip0_valid && !ip0_ready && ip0_out.wb_en && (ip0_out.dst == rsrc))
            ready = 1'b0;
        if (ip1_valid && !ip1_ready && ip1_out.wb_en && (ip1_out.dst == rsrc))
            ready = 1'b0;
        if (wb_hit(lsp_wb, rsrc)) begin
            ready = 1'b1;
            value = lsp_wb.result;
        end
        if (lsp_mem_hit)
            ready = 1'b0;
        if (mem_forward && lsp_mem_hit && lsp_mem.result_valid) begin
            ready = 1'b1;
            value = lsp_mem.result;
        end
        // Load still waiting in the address stage
        if (lsp_valid && lsp_out.wb_en && (lsp_out.dst == rsrc))
            ready = 1'b0;
        // x0 ignores any write that targets it
        if (rsrc == '0) begin
            ready = 1'b1;
            value = '0;
        end
    end

endmodule

// ==== verilog/ix_issue_ctrl.sv ====
`timescale 1ns/1ps

module ix_issue_ctrl import ix_isa_pkg::*; import ix_pipe_pkg::*; (
    input  logic        rst,
    input  logic        flush,
    input  dec_bundle_t dec0,
    input  logic        dec0_valid,
    input  dec_bundle_t dec1,
    input  logic        dec1_valid,
    input  logic [3:0]  src_ready,
    input  logic        ip0_ready,
    input  logic        ip1_ready,
    input  logic        lsp_ready,
    input  ip_req_t     ip0_out,
    input  logic        ip0_valid,
    input  ip_req_t     ip1_out,
    input  logic        ip1_valid,
    input  wb_bus_t     ip0_wb,
    input  wb_bus_t     ip1_wb,
    input  lsp_req_t    lsp_out,
    input  logic        lsp_valid,
    input  lsp_mem_t    lsp_mem,
    output logic        issue_ip0,
    output logic        issue_ip1,
    output logic        issue_lsp,
    output logic        lsp_from_slot1,
    output logic        dec0_ready,
    output logic        dec1_ready
);

    // rs1 also counts when it feeds the branch base
    function automatic logic uses_rs1(input dec_bundle_t d);
        return (d.opr1_src == opr1_rs1) ||
            ((d.op_type == ot_branch) && (d.br_base_src == bb_rs1));
    endfunction

    function automatic logic ip_clear(input ip_req_t req, input logic valid,
            input wb_bus_t wb, input reg_idx_t rd);
        return !(valid && req.wb_en && (req.dst == rd)) && !wb_hit(wb, rd);
    endfunction

    function automatic logic lsp_clear(input lsp_req_t req, input logic valid,
            input lsp_mem_t mem, input reg_idx_t rd);
        return !(valid && req.wb_en && (req.dst == rd)) &&
            !(mem.busy && mem.wb_en && (mem.dst == rd));
    endfunction

    logic can_issue, opr_ready0, opr_ready1, pair_ok;
    logic waw_ip0, waw_ip1, waw_ls0, waw_ls1;
    logic is_ip0, is_ip1, is_br0, is_br1, is_ls0, is_ls1;
    logic lsp0, lsp1;

    assign can_issue = !rst && !flush && dec0_valid;
    assign is_br0 = (dec0.op_type == ot_branch);
    assign is_br1 = (dec1.op_type == ot_branch);
    assign is_ip0 = (dec0.op_type == ot_int) || is_br0;
    assign is_ip1 = (dec1.op_type == ot_int) || is_br1;
    assign is_ls0 = (dec0.op_type == ot_load) || (dec0.op_type == ot_store);
    assign is_ls1 = (dec1.op_type == ot_load) || (dec1.op_type == ot_store);

    assign opr_ready0 = (!uses_rs1(dec0) || src_ready[0]) &&
        ((dec0.opr2_src != opr2_rs2) || src_ready[1]);
    assign opr_ready1 = (!uses_rs1(dec1) || src_ready[2]) &&
        ((dec1.opr2_src != opr2_rs2) || src_ready[3]);

    // Integer results retire ahead of loads, so an integer issue only checks the LSP
    assign waw_ip0 = !dec0.wb_en || lsp_clear(lsp_out, lsp_valid, lsp_mem, dec0.rd);
    assign waw_ip1 = !dec1.wb_en || lsp_clear(lsp_out, lsp_valid, lsp_mem, dec1.rd);
    assign waw_ls0 = !dec0.wb_en || (ip_clear(ip0_out, ip0_valid, ip0_wb, dec0.rd) &&
        ip_clear(ip1_out, ip1_valid, ip1_wb, dec0.rd));
    assign waw_ls1 = !dec1.wb_en || (ip_clear(ip0_out, ip0_valid, ip0_wb, dec1.rd) &&
        ip_clear(ip1_out, ip1_valid, ip1_wb, dec1.rd));

    // Slot 1 must not depend on slot 0 in any way
    assign pair_ok = dec1_valid && opr_ready1 &&
        ((dec0.rd != dec1.rd) || !(dec0.wb_en && dec1.wb_en)) &&
        (!dec0.wb_en || ((!uses_rs1(dec1) || (dec1.rs1 != dec0.rd)) &&
        ((dec1.opr2_src != opr2_rs2) || (dec1.rs2 != dec0.rd)))) &&
        (!is_br0 || (dec1.op_type == ot_int) || (dec1.op_type == ot_load));

    always_comb begin
        issue_ip0 = 1'b0;
        issue_ip1 = 1'b0;
        lsp0 = 1'b0;
        lsp1 = 1'b0;
        if (can_issue && opr_ready0) begin
            if (is_ip0 && (!is_br0 || !lsp_valid) && waw_ip0 && ip0_ready)
                issue_ip0 = 1'b1;
            else if (is_ls0 && waw_ls0 && lsp_ready)
                lsp0 = 1'b1;
        end
        if ((issue_ip0 || lsp0) && pair_ok) begin
            if (is_ip1 && (!is_br1 || (!lsp_valid && !lsp0)) && waw_ip1 && ip1_ready)
                issue_ip1 = 1'b1;
            else if (is_ls1 && !lsp0 && waw_ls1 && lsp_ready)
                lsp1 = 1'b1;
        end
    end

    assign issue_lsp = lsp0 || lsp1;
    assign lsp_from_slot1 = lsp1;
    assign dec0_ready = issue_ip0 || lsp0;
    assign dec1_ready = issue_ip1 || lsp1;

endmodule

// ==== verilog/ix_dispatch_regs.sv ====
`timescale 1ns/1ps

module ix_dispatch_regs import ix_isa_pkg::*; import ix_pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  issue_ip0,
    input  logic                  issue_ip1,
    input  logic                  issue_lsp,
    input  logic                  lsp_from_slot1,
    input  dec_bundle_t           dec0,
    input  dec_bundle_t           dec1,
    input  logic [3:0][xlen-1:0]  src_value,
    input  logic                  ip0_ready,
    input  logic                  ip1_ready,
    input  logic                  lsp_ready,
    output ip_req_t               ip0_out,
    output logic                  ip0_valid,
    output ip_req_t               ip1_out,
    output logic                  ip1_valid,
    output lsp_req_t              lsp_out,
    output logic                  lsp_valid
);

    function automatic logic [xlen-1:0] opr1_val(input dec_bundle_t d,
            input logic [xlen-1:0] rs1_val);
        if (d.br_inj_pc || (d.opr1_src == opr1_pc))
            return d.pc;
        case (d.opr1_src)
            opr1_rs1:  return rs1_val;
            opr1_zimm: return {{(xlen-5){1'b0}}, d.rs1};
            default:   return '0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] opr2_val(input dec_bundle_t d,
            input logic [xlen-1:0] rs2_val);
        case (d.opr2_src)
            opr2_rs2:  return rs2_val;
            opr2_imm:  return d.imm;
            default:   return xlen'(4);
        endcase
    endfunction

    function automatic ip_req_t make_ip_req(input dec_bundle_t d,
            input logic [xlen-1:0] rs1_val, input logic [xlen-1:0] rs2_val);
        ip_req_t r;
        r.pc = d.pc;
        r.dst = d.rd;
        r.wb_en = d.wb_en;
        r.op = d.op;
        r.option = d.option;
        r.truncate = d.truncate;
        r.br_type = d.br_type;
        r.br_neg = d.br_neg;
        r.br_base = (d.br_base_src == bb_pc) ? d.pc : rs1_val;
        r.br_offset = d.imm[br_off_w-1:0];
        r.br_is_call = d.br_is_call;
        r.br_is_ret = d.br_is_ret;
        r.operand1 = opr1_val(d, rs1_val);
        r.operand2 = opr2_val(d, rs2_val);
        return r;
    endfunction

    dec_bundle_t ls_dec;
    logic [xlen-1:0] ls_rs1, ls_rs2;

    assign ls_dec = lsp_from_slot1 ? dec1 : dec0;
    assign ls_rs1 = lsp_from_slot1 ? src_value[2] : src_value[0];
    assign ls_rs2 = lsp_from_slot1 ? src_value[3] : src_value[1];

    always_ff @(posedge clk) begin
        if (issue_ip0)
            ip0_out <= make_ip_req(dec0, src_value[0], src_value[1]);
        if (issue_ip1)
            ip1_out <= make_ip_req(dec1, src_value[2], src_value[3]);
        if (issue_lsp) begin
            lsp_out.pc <= ls_dec.pc;
            lsp_out.dst <= ls_dec.rd;
            lsp_out.wb_en <= ls_dec.wb_en;
            lsp_out.base <= opr1_val(ls_dec, ls_rs1);
            lsp_out.offset <= ls_dec.imm[ls_off_w-1:0];
            lsp_out.source <= opr2_val(ls_dec, ls_rs2);
            lsp_out.mem_sign <= ls_dec.mem_sign;
            lsp_out.mem_width <= ls_dec.mem_width;
        end
    end

    // A refill on the transfer edge keeps the register full
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ip0_valid <= 1'b0;
            ip1_valid <= 1'b0;
            lsp_valid <= 1'b0;
        end else begin
            if (issue_ip0)
                ip0_valid <= 1'b1;
            else if (ip0_ready)
                ip0_valid <= 1'b0;
            if (issue_ip1)
                ip1_valid <= 1'b1;
            else if (ip1_ready)
                ip1_valid <= 1'b0;
            if (issue_lsp)
                lsp_valid <= 1'b1;
            else if (lsp_ready)
                lsp_valid <= 1'b0;
        end
    end

endmodule

// ==== verilog/ix_top.sv ====
`timescale 1ns/1ps

module ix_top import ix_isa_pkg::*; import ix_pipe_pkg::*; #(
    parameter bit mem_forward = 1'b0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  dec_bundle_t     dec0,
    input  logic            dec0_valid,
    output logic            dec0_ready,
    input  dec_bundle_t     dec1,
    input  logic            dec1_valid,
    output logic            dec1_ready,
    output reg_idx_t        rf_rsrc0,
    output reg_idx_t        rf_rsrc1,
    output reg_idx_t        rf_rsrc2,
    output reg_idx_t        rf_rsrc3,
    input  logic [xlen-1:0] rf_rdata0,
    input  logic [xlen-1:0] rf_rdata1,
    input  logic [xlen-1:0] rf_rdata2,
    input  logic [xlen-1:0] rf_rdata3,
    output ip_req_t         ip0_req,
    output logic            ip0_valid,
    input  logic            ip0_ready,
    output ip_req_t         ip1_req,
    output logic            ip1_valid,
    input  logic            ip1_ready,
    output lsp_req_t        lsp_req,
    output logic            lsp_valid,
    input  logic            lsp_ready,
    input  wb_bus_t         wb_buf,
    input  wb_bus_t         ip0_wb,
    input  wb_bus_t         ip1_wb,
    input  wb_bus_t         lsp_wb,
    input  ex_fwd_t         ip0_fwd,
    input  ex_fwd_t         ip1_fwd,
    input  lsp_mem_t        lsp_mem
);

    reg_idx_t [3:0]        src_idx;
    logic [3:0][xlen-1:0]  rf_data;
    logic [3:0][xlen-1:0]  src_value;
    logic [3:0]            src_ready;
    logic issue_ip0, issue_ip1, issue_lsp, lsp_from_slot1;

    // Sources in order: slot 0 rs1, rs2, then slot 1 rs1, rs2
    assign src_idx = {dec1.rs2, dec1.rs1, dec0.rs2, dec0.rs1};
    assign rf_rsrc0 = src_idx[0];
    assign rf_rsrc1 = src_idx[1];
    assign rf_rsrc2 = src_idx[2];
    assign rf_rsrc3 = src_idx[3];
    assign rf_data = {rf_rdata3, rf_rdata2, rf_rdata1, rf_rdata0};

    for (genvar i = 0; i < 4; i++) begin : g_bypass
        ix_operand_bypass #(.mem_forward(mem_forward)) u_bypass (
            .rsrc(src_idx[i]), .rf_rdata(rf_data[i]),
            .wb_buf(wb_buf), .ip0_wb(ip0_wb), .ip1_wb(ip1_wb), .lsp_wb(lsp_wb),
            .ip0_fwd(ip0_fwd), .ip1_fwd(ip1_fwd), .lsp_mem(lsp_mem),
            .ip0_out(ip0_req), .ip0_valid(ip0_valid), .ip0_ready(ip0_ready),
            .ip1_out(ip1_req), .ip1_valid(ip1_valid), .ip1_ready(ip1_ready),
            .lsp_out(lsp_req), .lsp_valid(lsp_valid),
            .value(src_value[i]), .ready(src_ready[i])
        );
    end

    ix_issue_ctrl u_issue_ctrl (
        .rst(rst), .flush(flush),
        .dec0(dec0), .dec0_valid(dec0_valid), .dec1(dec1), .dec1_valid(dec1_valid),
        .src_ready(src_ready),
        .ip0_ready(ip0_ready), .ip1_ready(ip1_ready), .lsp_ready(lsp_ready),
        .ip0_out(ip0_req), .ip0_valid(ip0_valid), .ip1_out(ip1_req), .ip1_valid(ip1_valid),
        .ip0_wb(ip0_wb), .ip1_wb(ip1_wb),
        .lsp_out(lsp_req), .lsp_valid(lsp_valid), .lsp_mem(lsp_mem),
        .issue_ip0(issue_ip0), .issue_ip1(issue_ip1), .issue_lsp(issue_lsp),
        .lsp_from_slot1(lsp_from_slot1),
        .dec0_ready(dec0_ready), .dec1_ready(dec1_ready)
    );

    ix_dispatch_regs u_dispatch_regs (
        .clk(clk), .rst(rst), .flush(flush),
        .issue_ip0(issue_ip0), .issue_ip1(issue_ip1), .issue_lsp(issue_lsp),
        .lsp_from_slot1(lsp_from_slot1),
        .dec0(dec0), .dec1(dec1), .src_value(src_value),
        .ip0_ready(ip0_ready), .ip1_ready(ip1_ready), .lsp_ready(lsp_ready),
        .ip0_out(ip0_req), .ip0_valid(ip0_valid),
        .ip1_out(ip1_req), .ip1_valid(ip1_valid),
        .lsp_out(lsp_req), .lsp_valid(lsp_valid)
    );

endmodule

// ==== sim/ix_tb.sv ====
`timescale 1ns/1ps

module ix_tb import ix_isa_pkg::*; import ix_pipe_pkg::*; ();

    localparam int cycle_limit = 400;

    logic clk = 1'b0;
    logic rst, flush;
    dec_bundle_t dec0, dec1;
    logic dec0_valid, dec0_ready, dec1_valid, dec1_ready;
    reg_idx_t rf_rsrc0, rf_rsrc1, rf_rsrc2, rf_rsrc3;
    logic [xlen-1:0] rf_rdata0, rf_rdata1, rf_rdata2, rf_rdata3;
    ip_req_t ip0_req, ip1_req;
    lsp_req_t lsp_req;
    logic ip0_valid, ip0_ready, ip1_valid, ip1_ready, lsp_valid, lsp_ready;
    wb_bus_t wb_buf, ip0_wb, ip1_wb, lsp_wb;
    ex_fwd_t ip0_fwd, ip1_fwd;
    lsp_mem_t lsp_mem;

    int errors = 0;
    int cycles = 0;
    logic [31:0] seed = 32'h3c884e68;

    // Expected value of one forwarded source while forwarding is staged
    logic ovr_valid;
    reg_idx_t ovr_idx;
    logic [xlen-1:0] ovr_val;
    logic [xlen-1:0] exp0_op1, exp0_op2, exp1_op1, exp1_op2;
    logic acc0_int, acc1_int, acc0_ls, s1_dep, s0_mem_dep;

    ix_top #(.mem_forward(1'b1)) dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    // Register file model where every index gives a distinct word
    function automatic logic [xlen-1:0] rf_value(input reg_idx_t idx);
        return 64'h9e37_79b9_7f4a_7c15 * (64'(idx) + 64'd1);
    endfunction

    assign rf_rdata0 = rf_value(rf_rsrc0);
    assign rf_rdata1 = rf_value(rf_rsrc1);
    assign rf_rdata2 = rf_value(rf_rsrc2);
    assign rf_rdata3 = rf_value(rf_rsrc3);

    function automatic logic [xlen-1:0] expected_src(input reg_idx_t idx, input logic ov,
            input reg_idx_t ov_idx, input logic [xlen-1:0] ov_val);
        if (idx == '0)
            return '0;
        if (ov && (idx == ov_idx))
            return ov_val;
        return rf_value(idx);
    endfunction

    always_comb begin
        exp0_op1 = expected_src(dec0.rs1, ovr_valid, ovr_idx, ovr_val);
        exp0_op2 = (dec0.opr2_src == opr2_imm) ? dec0.imm :
            expected_src(dec0.rs2, ovr_valid, ovr_idx, ovr_val);
        exp1_op1 = expected_src(dec1.rs1, ovr_valid, ovr_idx, ovr_val);
        exp1_op2 = (dec1.opr2_src == opr2_imm) ? dec1.imm :
            expected_src(dec1.rs2, ovr_valid, ovr_idx, ovr_val);
    end

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    assign acc0_int = dec0_valid && dec0_ready && (dec0.op_type == ot_int);
    assign acc1_int = dec1_valid && dec1_ready && (dec1.op_type == ot_int);
    assign acc0_ls = dec0_valid && dec0_ready && (dec0.op_type == ot_load);
    assign s1_dep = dec0.wb_en && (((dec1.opr1_src == opr1_rs1) && (dec1.rs1 == dec0.rd)) ||
        ((dec1.opr2_src == opr2_rs2) && (dec1.rs2 == dec0.rd)) ||
        (dec1.wb_en && (dec1.rd == dec0.rd)));
    assign s0_mem_dep = lsp_mem.busy && lsp_mem.wb_en && !lsp_mem.result_valid &&
        (lsp_mem.dst != '0) &&
        (((dec0.opr1_src == opr1_rs1) && (dec0.rs1 == lsp_mem.dst)) ||
        ((dec0.opr2_src == opr2_rs2) && (dec0.rs2 == lsp_mem.dst)));

    a_rst_ready: assert property (@(posedge clk) rst |-> !dec0_ready && !dec1_ready)
        else report_error("decoder ready high in reset");
    a_rst_valid: assert property (@(posedge clk)
        rst |=> !ip0_valid && !ip1_valid && !lsp_valid)
        else report_error("pipe valid high after reset");
    a_ip0_req: assert property (@(posedge clk) disable iff (rst) acc0_int |=> ip0_valid &&
        (ip0_req.dst == $past(dec0.rd)) && (ip0_req.operand1 == $past(exp0_op1)) &&
        (ip0_req.operand2 == $past(exp0_op2)))
        else report_error("ip0 request wrong");
    a_ip1_req: assert property (@(posedge clk) disable iff (rst) acc1_int |=> ip1_valid &&
        (ip1_req.dst == $past(dec1.rd)) && (ip1_req.operand1 == $past(exp1_op1)) &&
        (ip1_req.operand2 == $past(exp1_op2)))
        else report_error("ip1 request wrong");
    a_lsp_req: assert property (@(posedge clk) disable iff (rst) acc0_ls |=> lsp_valid &&
        (lsp_req.dst == $past(dec0.rd)) && (lsp_req.base == $past(exp0_op1)))
        else report_error("lsp request wrong");
    a_pair_dep: assert property (@(posedge clk) disable iff (rst)
        (dec0_valid && dec1_valid && s1_dep) |-> !dec1_ready)
        else report_error("dependent slot 1 accepted");
    a_one_lsp: assert property (@(posedge clk) disable iff (rst)
        (dec0_valid && dec1_valid && (dec0.op_type == ot_load) &&
        (dec1.op_type == ot_load)) |-> !(dec0_ready && dec1_ready))
        else report_error("two loads accepted together");
    a_mem_stall: assert property (@(posedge clk) disable iff (rst)
        (dec0_valid && s0_mem_dep) |-> !dec0_ready)
        else report_error("issue past lsp memory write");
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (ip0_valid && !ip0_ready && !flush) |=> ip0_valid && (ip0_req == $past(ip0_req)))
        else report_error("stalled ip0 output changed");
    a_no_issue: assert property (@(posedge clk) disable iff (rst) !ip0_ready |-> !acc0_int)
        else report_error("int issued to stalled ip0");
    a_flush_valid: assert property (@(posedge clk) disable iff (rst)
        flush |=> !ip0_valid && !ip1_valid && !lsp_valid)
        else report_error("pipe valid kept over flush");
    a_flush_ready: assert property (@(posedge clk) disable iff (rst)
        flush |-> !dec0_ready && !dec1_ready)
        else report_error("accepted during flush");

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Index in 1..31 that is stepped past avoid when it collides
    task automatic rand_idx(output reg_idx_t idx, input reg_idx_t avoid);
        seed = xorshift(seed);
        idx = 5'(seed % 31) + 5'd1;
        if (idx == avoid)
            idx = (idx == 5'd31) ? 5'd1 : idx + 5'd1;
    endtask

    task automatic make_int(output dec_bundle_t d, input reg_idx_t rd, input reg_idx_t rs1,
            input reg_idx_t rs2, input logic use_imm);
        d = '0;
        seed = xorshift(seed);
        d.pc = {32'd0, seed[31:2], 2'b00};
        d.op = seed[3:0];
        seed = xorshift(seed);
        d.imm = {{52{seed[11]}}, seed[11:0]};
        d.op_type = ot_int;
        d.opr1_src = opr1_rs1;
        d.opr2_src = use_imm ? opr2_imm : opr2_rs2;
        d.wb_en = 1'b1;
        d.rs1 = rs1;
        d.rs2 = rs2;
        d.rd = rd;
    endtask

    task automatic present(input dec_bundle_t d0, input logic v0, input dec_bundle_t d1,
            input logic v1);
        dec0 = d0;
        dec0_valid = v0;
        dec1 = d1;
        dec1_valid = v1;
    endtask

    // Decoder model that moves slot 1 to slot 0 when only slot 0 was taken
    task automatic wait_accept();
        logic acc0, acc1;
        while (dec0_valid || dec1_valid) begin
            @(negedge clk);
            acc0 = dec0_valid && dec0_ready;
            acc1 = dec1_valid && dec1_ready;
            @(posedge clk);
            #2;
            if (acc0) begin
                dec0 = dec1;
                dec0_valid = dec1_valid && !acc1;
                dec1_valid = 1'b0;
            end
        end
    endtask

    initial begin
        dec_bundle_t d0, d1;
        reg_idx_t a, b, c, r;
        rst = 1'b1;
        flush = 1'b0;
        dec0 = '0;
        dec1 = '0;
        // A ready pair of x0 instructions waits through reset
        dec0_valid = 1'b1;
        dec1_valid = 1'b1;
        ip0_ready = 1'b1;
        ip1_ready = 1'b1;
        lsp_ready = 1'b1;
        wb_buf = '0;
        ip0_wb = '0;
        ip1_wb = '0;
        lsp_wb = '0;
        ip0_fwd = '0;
        ip1_fwd = '0;
        lsp_mem = '0;
        ovr_valid = 1'b0;
        ovr_idx = '0;
        ovr_val = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // Independent int pairs where the first one reads x0 in both slots
        for (int i = 0; i < 6; i++) begin
            rand_idx(r, 5'd0);
            rand_idx(a, 5'd0);
            rand_idx(b, 5'd0);
            make_int(d0, r, (i == 0) ? 5'd0 : a, b, (i > 0) && seed[7]);
            rand_idx(a, r);
            rand_idx(b, r);
            rand_idx(c, r);
            make_int(d1, c, a, (i == 0) ? 5'd0 : b, 1'b0);
            present(d0, 1'b1, d1, 1'b1);
            wait_accept();
        end

        // Slot 1 reads slot 0's rd, then targets the same rd, then two loads
        rand_idx(r, 5'd0);
        rand_idx(b, r);
        make_int(d0, r, b, b, 1'b0);
        make_int(d1, b, r, b, 1'b1);
        present(d0, 1'b1, d1, 1'b1);
        wait_accept();
        rand_idx(a, r);
        make_int(d1, r, a, a, 1'b0);
        present(d0, 1'b1, d1, 1'b1);
        wait_accept();
        rand_idx(a, 5'd0);
        rand_idx(r, a);
        rand_idx(c, r);
        make_int(d0, r, a, a, 1'b1);
        d0.op_type = ot_load;
        make_int(d1, c, a, a, 1'b1);
        d1.op_type = ot_load;
        present(d0, 1'b1, d1, 1'b1);
        wait_accept();

        // Execute forwarding of the accepted ip0 request beats ip0 writeback
        rand_idx(r, 5'd0);
        rand_idx(a, r);
        make_int(d0, r, a, a, 1'b0);
        present(d0, 1'b1, d0, 1'b0);
        wait_accept();
        ip0_wb = '{valid: 1'b1, wb_en: 1'b1, dst: r, result: 64'h1111_2222_3333_4444};
        ip0_fwd = '{value: 64'h5555_6666_7777_8888, dst: r};
        ovr_idx = r;
        ovr_val = 64'h5555_6666_7777_8888;
        ovr_valid = 1'b1;
        make_int(d0, a, r, r, 1'b0);
        present(d0, 1'b1, d0, 1'b0);
        wait_accept();
        ip0_wb = '0;
        ip0_fwd = '0;
        ovr_valid = 1'b0;

        // Pending lsp memory write holds the reader back until it clears
        rand_idx(r, 5'd0);
        rand_idx(a, r);
        lsp_mem = '{busy: 1'b1, wb_en: 1'b1, dst: r, result: '0, result_valid: 1'b0};
        make_int(d0, a, r, a, 1'b1);
        present(d0, 1'b1, d0, 1'b0);
        repeat (4) @(posedge clk);
        #2;
        lsp_mem = '0;
        wait_accept();

        // ip0 stalled by its pipe
        rand_idx(r, 5'd0);
        rand_idx(a, r);
        make_int(d0, r, a, a, 1'b1);
        present(d0, 1'b1, d0, 1'b0);
        wait_accept();
        ip0_ready = 1'b0;
        make_int(d0, a, a, a, 1'b1);
        present(d0, 1'b1, d0, 1'b0);
        repeat (4) @(posedge clk);
        #2;
        ip0_ready = 1'b1;
        wait_accept();

        // Flush while ip1 is stalled and a new pair is waiting
        rand_idx(r, 5'd0);
        rand_idx(c, r);
        make_int(d0, r, r, r, 1'b1);
        make_int(d1, c, r, r, 1'b1);
        d1.rs1 = 5'd0;
        d1.opr2_src = opr2_imm;
        present(d0, 1'b1, d1, 1'b1);
        wait_accept();
        present(d0, 1'b1, d1, 1'b1);
        flush = 1'b1;
        ip1_ready = 1'b0;
        @(posedge clk);
        #2;
        flush = 1'b0;
        ip1_ready = 1'b1;
        wait_accept();

        repeat (3) @(posedge clk);
        $display("Checks done: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== list.f ====
verilog/ix_isa_pkg.sv
verilog/ix_pipe_pkg.sv
verilog/ix_operand_bypass.sv
verilog/ix_issue_ctrl.sv
verilog/ix_dispatch_regs.sv
verilog/ix_top.sv
sim/ix_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= ix_tb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
